/* sim.f */
hdl/axis_in_pkg.sv
hdl/axis_in_regs.sv
hdl/axis_in_fifo.sv
hdl/axis_in_capture.sv
hdl/axis_in_drain.sv
hdl/axis_in_top.sv
dv/axis_in_properties.sv
dv/axis_in_tb.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --timing --assert -j 0
TOP       ?= axis_in_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := Simulation finished: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* dv/axis_in_tb.sv */
module axis_in_tb;

   import axis_in_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int RESET_CYCLES = 10;
   localparam int SAMPLE_DLY   = CLK_PERIOD / 4;

   // table operations
   localparam int OP_WR   = 0;
   localparam int OP_RD   = 1;
   localparam int OP_PUSH = 2;
   localparam int OP_TAKE = 3;
   localparam int OP_CPU  = 4;
   localparam int OP_IRQ  = 5;
   localparam int OP_RDY  = 6;

   logic                  clk_i;
   logic                  reset_i;
   logic                  psel_i;
   logic                  penable_i;
   logic                  pwrite_i;
   logic [APB_ADDR_W-1:0] paddr_i;
   logic [DATA_W-1:0]     pwdata_i;
   logic [DATA_W-1:0]     prdata_o;
   logic                  pready_o;
   logic                  pslverr_o;
   logic                  s_tvalid_i;
   logic [DATA_W-1:0]     s_tdata_i;
   logic                  s_tlast_i;
   logic                  s_tready_o;
   logic                  dma_tvalid_o;
   logic [DATA_W-1:0]     dma_tdata_o;
   logic                  dma_tready_i;
   logic                  interrupt_o;

   // stimulus table with one entry per row in each queue
   int          op_q[$];
   logic [31:0] addr_q[$];
   logic [31:0] data_q[$];
   logic        err_q[$];

   // words expected out of the dma or cpu side in push order
   logic [31:0] model_q[$];

   integer seed        = 32'ha280;
   int     cycles      = 0;
   int     cycle_limit = 1000000;

   axis_in_top u_dut (.*);

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD/2) clk_i = ~clk_i;
   end

   always @(posedge clk_i) begin
      cycles <= cycles + 1;
      if (cycles >= cycle_limit) begin
         $display("timeout: the run went past %0d cycles without finishing", cycle_limit);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[FAIL] time %0t %s got %h expected %h", $time, name, got, exp);
         $display("Simulation finished: FAIL");
         $fatal(1);
      end
   endtask

   task automatic add_rows(input int op, input logic [31:0] a, input logic [31:0] d,
                           input logic e, input int n = 1);
      repeat (n) begin
         op_q.push_back(op);
         addr_q.push_back(a);
         data_q.push_back(d);
         err_q.push_back(e);
      end
   endtask

   // setup then access phase with outputs sampled mid low phase
   task automatic apb_transfer(input logic wr, input logic [31:0] a, input logic [31:0] d,
                               input logic e, input logic chk_data);
      psel_i    = 1'b1;
      penable_i = 1'b0;
      pwrite_i  = wr;
      paddr_i   = a[APB_ADDR_W-1:0];
      pwdata_i  = wr ? d : '0;
      @(negedge clk_i);
      penable_i = 1'b1;
      #(SAMPLE_DLY);
      check("pready_o", pready_o, 1'b1);
      check("pslverr_o", pslverr_o, e);
      if (!wr && chk_data) begin
         check("prdata_o", prdata_o, d);
      end
      @(negedge clk_i);
      psel_i    = 1'b0;
      penable_i = 1'b0;
   endtask

   task automatic stream_push(input logic last);
      logic [31:0] w;
      w          = $random(seed);
      s_tvalid_i = 1'b1;
      s_tdata_i  = w;
      s_tlast_i  = last;
      #(SAMPLE_DLY);
      while (!s_tready_o) begin
         @(negedge clk_i);
         #(SAMPLE_DLY);
      end
      model_q.push_back(w);
      @(negedge clk_i);
      s_tvalid_i = 1'b0;
      s_tlast_i  = 1'b0;
   endtask

   task automatic dma_take();
      dma_tready_i = 1'b1;
      #(SAMPLE_DLY);
      while (!dma_tvalid_o) begin
         @(negedge clk_i);
         #(SAMPLE_DLY);
      end
      check("dma_tdata_o", dma_tdata_o, model_q.pop_front());
      @(negedge clk_i);
      dma_tready_i = 1'b0;
   endtask

   task automatic sample_bit(input string name, input logic exp);
      #(SAMPLE_DLY);
      if (name == "interrupt_o") begin
         check(name, interrupt_o, exp);
      end else begin
         check(name, s_tready_o, exp);
      end
      @(negedge clk_i);
   endtask

   task automatic build_table();
      // reset values, threshold write and bad offset
      add_rows(OP_RD, REG_THRESH, 16, 0);
      add_rows(OP_RD, REG_LEVEL, 0, 0);
      add_rows(OP_RD, REG_NWORDS, 0, 0);
      add_rows(OP_RD, REG_STATUS, 32'h1, 0);
      add_rows(OP_RD, REG_CTRL, 0, 0);
      add_rows(OP_WR, REG_THRESH, 3, 0);
      add_rows(OP_RD, REG_THRESH, 3, 0);
      add_rows(OP_RD, 32'h18, 0, 1);
      add_rows(OP_RDY, 0, 0, 0);
      // enable and stream through to dma
      add_rows(OP_WR, REG_CTRL, 1, 0);
      add_rows(OP_RDY, 0, 1, 0);
      add_rows(OP_PUSH, 0, 0, 0, 3);
      add_rows(OP_RD, REG_LEVEL, 2, 0);
      add_rows(OP_IRQ, 0, 0, 0);
      add_rows(OP_PUSH, 0, 0, 0);
      add_rows(OP_IRQ, 0, 1, 0);
      add_rows(OP_RD, REG_NWORDS, 4, 0);
      add_rows(OP_TAKE, 0, 0, 0);
      add_rows(OP_IRQ, 0, 0, 0);
      add_rows(OP_TAKE, 0, 0, 0, 3);
      add_rows(OP_RD, REG_STATUS, 32'h1, 0);
      // last word freezes the count
      add_rows(OP_PUSH, 1, 0, 0);
      add_rows(OP_PUSH, 0, 0, 0, 2);
      add_rows(OP_RD, REG_STATUS, 32'hC, 0);
      add_rows(OP_RD, REG_NWORDS, 5, 0);
      add_rows(OP_TAKE, 0, 0, 0, 3);
      // back-pressure with 16 queued and one held
      add_rows(OP_PUSH, 0, 0, 0, 17);
      add_rows(OP_RDY, 0, 0, 0);
      add_rows(OP_RD, REG_STATUS, 32'hE, 0);
      add_rows(OP_RD, REG_LEVEL, 16, 0);
      add_rows(OP_IRQ, 0, 1, 0);
      add_rows(OP_TAKE, 0, 0, 0);
      add_rows(OP_RDY, 0, 1, 0);
      add_rows(OP_TAKE, 0, 0, 0, 14);
      add_rows(OP_RD, REG_LEVEL, 1, 0);
      add_rows(OP_IRQ, 0, 0, 0);
      // cpu pops, then soft reset
      add_rows(OP_CPU, 0, 0, 0, 2);
      add_rows(OP_RD, REG_DATA, 0, 1);
      add_rows(OP_PUSH, 0, 0, 0, 2);
      add_rows(OP_WR, REG_CTRL, 3, 0);
      add_rows(OP_RD, REG_LEVEL, 0, 0);
      add_rows(OP_RD, REG_NWORDS, 0, 0);
      add_rows(OP_RD, REG_STATUS, 32'h1, 0);
      add_rows(OP_RDY, 0, 1, 0);
   endtask

   initial begin
      logic [31:0] front;
      reset_i      = 1'b1;
      psel_i       = 1'b0;
      penable_i    = 1'b0;
      pwrite_i     = 1'b0;
      paddr_i      = '0;
      pwdata_i     = '0;
      s_tvalid_i   = 1'b0;
      s_tdata_i    = '0;
      s_tlast_i    = 1'b0;
      dma_tready_i = 1'b0;
      build_table();
      cycle_limit = op_q.size() * 40 + RESET_CYCLES;
      repeat (RESET_CYCLES) @(negedge clk_i);
      reset_i = 1'b0;
      @(negedge clk_i);
      for (int i = 0; i < op_q.size(); i++) begin
         case (op_q[i])
            OP_WR: begin
               apb_transfer(1'b1, addr_q[i], data_q[i], err_q[i], 1'b0);
               // soft reset throws away everything in flight
               if (addr_q[i][APB_ADDR_W-1:0] == REG_CTRL && data_q[i][CTRL_SOFT_RESET_BIT]) begin
                  model_q.delete();
               end
            end
            OP_RD:   apb_transfer(1'b0, addr_q[i], data_q[i], err_q[i], !err_q[i]);
            OP_CPU: begin
               front = model_q.pop_front();
               apb_transfer(1'b0, REG_DATA, front, 1'b0, 1'b1);
            end
            OP_PUSH: stream_push(addr_q[i][0]);
            OP_TAKE: dma_take();
            OP_IRQ:  sample_bit("interrupt_o", data_q[i][0]);
            default: sample_bit("s_tready_o", data_q[i][0]);
         endcase
      end
      $display("Simulation finished: PASS");
      $finish;
   end

endmodule

/* dv/axis_in_properties.sv */
module axis_in_properties (
   input logic clk_i,
   input logic reset_i,
   input logic psel_i,
   input logic penable_i,
   input logic pready_o,
   input logic pslverr_o,
   input logic enable_i,
   input logic soft_reset_i,
   input logic cpu_pop_i,
   input logic s_tready_o,
   input logic dma_tvalid_o,
   input logic dma_tready_i,
   input logic interrupt_o
);

   // no room to accept while the block is disabled
   assert property (@(posedge clk_i) disable iff (reset_i) !enable_i |-> !s_tready_o)
      else $error("s_tready_o high while enable is low");

   // held word stays until dma or cpu takes it
   assert property (@(posedge clk_i) disable iff (reset_i || soft_reset_i)
      dma_tvalid_o && !(dma_tready_i || cpu_pop_i) |=> dma_tvalid_o)
      else $error("dma_tvalid_o dropped before the word was consumed");

   assert property (@(posedge clk_i) psel_i && penable_i |-> pready_o)
      else $error("pready_o low in an access phase");

   assert property (@(posedge clk_i)
      reset_i |=> !s_tready_o && !dma_tvalid_o && !pslverr_o && !interrupt_o)
      else $error("outputs active right after reset");

endmodule

bind axis_in_top axis_in_properties u_props (
   .clk_i        (clk_i),
   .reset_i      (reset_i),
   .psel_i       (psel_i),
   .penable_i    (penable_i),
   .pready_o     (pready_o),
   .pslverr_o    (pslverr_o),
   .enable_i     (enable),
   .soft_reset_i (soft_reset),
   .cpu_pop_i    (cpu_pop),
   .s_tready_o   (s_tready_o),
   .dma_tvalid_o (dma_tvalid_o),
   .dma_tready_i (dma_tready_i),
   .interrupt_o  (interrupt_o)
);

/* hdl/axis_in_top.sv */
module axis_in_top (
   input  logic                              clk_i,
   input  logic                              reset_i,
   // apb slave
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [axis_in_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     pwdata_i,
   output logic [axis_in_pkg::DATA_W-1:0]     prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,
   // input stream
   input  logic                              s_tvalid_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     s_tdata_i,
   input  logic                              s_tlast_i,
   output logic                              s_tready_o,
   // dma stream
   output logic                              dma_tvalid_o,
   output logic [axis_in_pkg::DATA_W-1:0]     dma_tdata_o,
   input  logic                              dma_tready_i,
   output logic                              interrupt_o
);

   import axis_in_pkg::*;

   logic                enable;
   logic                soft_reset;
   logic [LEVEL_W-1:0]  threshold;
   logic                cpu_pop;
   logic                fifo_write;
   logic                fifo_read;
   logic [DATA_W-1:0]   fifo_data;
   logic                fifo_empty;
   logic                fifo_full;
   logic [LEVEL_W-1:0]  fifo_level;
   logic [DATA_W-1:0]   nwords;
   logic                tlast_seen;

   axis_in_regs u_regs (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .psel_i       (psel_i),
      .penable_i    (penable_i),
      .pwrite_i     (pwrite_i),
      .paddr_i      (paddr_i),
      .pwdata_i     (pwdata_i),
      .prdata_o     (prdata_o),
      .pready_o     (pready_o),
      .pslverr_o    (pslverr_o),
      .level_i      (fifo_level),
      .empty_i      (fifo_empty),
      .full_i       (fifo_full),
      .tlast_seen_i (tlast_seen),
      .nwords_i     (nwords),
      .hold_valid_i (dma_tvalid_o),
      .hold_data_i  (dma_tdata_o),
      .enable_o     (enable),
      .soft_reset_o (soft_reset),
      .threshold_o  (threshold),
      .cpu_pop_o    (cpu_pop)
   );

   axis_in_capture u_capture (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .soft_reset_i (soft_reset),
      .enable_i     (enable),
      .fifo_full_i  (fifo_full),
      .s_tvalid_i   (s_tvalid_i),
      .s_tlast_i    (s_tlast_i),
      .s_tready_o   (s_tready_o),
      .fifo_write_o (fifo_write),
      .nwords_o     (nwords),
      .tlast_seen_o (tlast_seen)
   );

   axis_in_fifo #(
      .DATA_W      (DATA_W),
      .FIFO_ADDR_W (FIFO_ADDR_W)
   ) u_fifo (
      .clk_i     (clk_i),
      .reset_i   (reset_i),
      .clear_i   (soft_reset),
      .wr_en_i   (fifo_write),
      .wr_data_i (s_tdata_i),
      .rd_en_i   (fifo_read),
      .rd_data_o (fifo_data),
      .empty_o   (fifo_empty),
      .full_o    (fifo_full),
      .level_o   (fifo_level)
   );

   axis_in_drain u_drain (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .soft_reset_i (soft_reset),
      .fifo_empty_i (fifo_empty),
      .fifo_data_i  (fifo_data),
      .fifo_read_o  (fifo_read),
      .dma_tvalid_o (dma_tvalid_o),
      .dma_tdata_o  (dma_tdata_o),
      .dma_tready_i (dma_tready_i),
      .cpu_pop_i    (cpu_pop)
   );

   // level interrupt, the word held in the drain stage is not counted
   assign interrupt_o = (fifo_level >= threshold);

endmodule

/* hdl/axis_in_drain.sv */
module axis_in_drain (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          soft_reset_i,
   // fifo read side
   input  logic                          fifo_empty_i,
   input  logic [axis_in_pkg::DATA_W-1:0] fifo_data_i,
   output logic                          fifo_read_o,
   // dma stream out
   output logic                          dma_tvalid_o,
   output logic [axis_in_pkg::DATA_W-1:0] dma_tdata_o,
   input  logic                          dma_tready_i,
   // cpu pop through the data register
   input  logic                          cpu_pop_i
);

   // 0 = idle, 1 = holding a word
   logic holding_q;
   logic consume;
   logic need_word;

   // dma and cpu may pop together, still only one word leaves
   assign consume = holding_q & (dma_tready_i | cpu_pop_i);

   // refill when idle or when the held word goes away this cycle
   assign need_word = ~holding_q | consume;

   assign fifo_read_o = need_word & ~fifo_empty_i & ~soft_reset_i;

   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         holding_q <= 1'b0;
      end else begin
         case (holding_q)
            1'b0: begin
               if (!fifo_empty_i) begin
                  holding_q <= 1'b1;
               end
            end
            default: begin
               // back to idle only when nothing is left to fetch
               if (consume && fifo_empty_i) begin
                  holding_q <= 1'b0;
               end
            end
         endcase
      end
   end

   assign dma_tvalid_o = holding_q;

   // fifo read register holds the word until the next read
   assign dma_tdata_o = fifo_data_i;

endmodule

/* hdl/axis_in_capture.sv */
module axis_in_capture (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          soft_reset_i,
   input  logic                          enable_i,
   input  logic                          fifo_full_i,
   // input stream handshake
   input  logic                          s_tvalid_i,
   input  logic                          s_tlast_i,
   output logic                          s_tready_o,
   // fifo write strobe, data goes straight to the fifo
   output logic                          fifo_write_o,
   // frame bookkeeping
   output logic [axis_in_pkg::DATA_W-1:0] nwords_o,
   output logic                          tlast_seen_o
);

   logic accept;
   logic count_en;

   // ready only when enabled and there is room
   assign s_tready_o = enable_i & ~fifo_full_i;

   assign accept       = s_tvalid_i & s_tready_o;
   assign fifo_write_o = accept;

   // the last-marked word still counts since the flag is set after it
   assign count_en = accept & ~tlast_seen_o;

   // accepted word counter
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         nwords_o <= '0;
      end else if (count_en) begin
         nwords_o <= nwords_o + 1'b1;
      end
   end

   // sticky once the first last-marked word is taken
   always_ff @(posedge clk_i) begin
      if (reset_i || soft_reset_i) begin
         tlast_seen_o <= 1'b0;
      end else if (accept && s_tlast_i) begin
         tlast_seen_o <= 1'b1;
      end
   end

endmodule

/* hdl/axis_in_fifo.sv */
module axis_in_fifo #(
   parameter int DATA_W      = axis_in_pkg::DATA_W,
   parameter int FIFO_ADDR_W = axis_in_pkg::FIFO_ADDR_W
) (
   input  logic                   clk_i,
   input  logic                   reset_i,
   input  logic                   clear_i,
   // write side
   input  logic                   wr_en_i,
   input  logic [DATA_W-1:0]      wr_data_i,
   // read side, data appears one cycle after rd_en_i
   input  logic                   rd_en_i,
   output logic [DATA_W-1:0]      rd_data_o,
   output logic                   empty_o,
   output logic                   full_o,
   output logic [FIFO_ADDR_W:0]   level_o
);

   logic [DATA_W-1:0]      mem [0:(2**FIFO_ADDR_W)-1];
   logic [FIFO_ADDR_W-1:0] wr_ptr_q;
   logic [FIFO_ADDR_W-1:0] rd_ptr_q;
   logic [FIFO_ADDR_W:0]   level_q;
   logic                   do_write;
   logic                   do_read;

   // protect against overrun and underrun
   assign do_write = wr_en_i & ~full_o;
   assign do_read  = rd_en_i & ~empty_o;

   // storage
   always_ff @(posedge clk_i) begin
      if (do_write) begin
         mem[wr_ptr_q] <= wr_data_i;
      end
   end

   // registered read port
   always_ff @(posedge clk_i) begin
      if (do_read) begin
         rd_data_o <= mem[rd_ptr_q];
      end
   end

   // pointers wrap on their own since depth is a power of two
   always_ff @(posedge clk_i) begin
      if (reset_i || clear_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
      end else begin
         if (do_write) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (do_read) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
      end
   end

   // occupancy
   always_ff @(posedge clk_i) begin
      if (reset_i || clear_i) begin
         level_q <= '0;
      end else begin
         case ({do_write, do_read})
            2'b10:   level_q <= level_q + 1'b1;
            2'b01:   level_q <= level_q - 1'b1;
            default: level_q <= level_q;
         endcase
      end
   end

   assign level_o = level_q;
   assign empty_o = (level_q == '0);
   // msb only set at exactly full depth
   assign full_o  = level_q[FIFO_ADDR_W];

endmodule

/* hdl/axis_in_regs.sv */
module axis_in_regs (
   input  logic                              clk_i,
   input  logic                              reset_i,
   // apb slave
   input  logic                              psel_i,
   input  logic                              penable_i,
   input  logic                              pwrite_i,
   input  logic [axis_in_pkg::APB_ADDR_W-1:0] paddr_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     pwdata_i,
   output logic [axis_in_pkg::DATA_W-1:0]     prdata_o,
   output logic                              pready_o,
   output logic                              pslverr_o,
   // status from the data path
   input  logic [axis_in_pkg::LEVEL_W-1:0]    level_i,
   input  logic                              empty_i,
   input  logic                              full_i,
   input  logic                              tlast_seen_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     nwords_i,
   input  logic                              hold_valid_i,
   input  logic [axis_in_pkg::DATA_W-1:0]     hold_data_i,
   // control to the data path
   output logic                              enable_o,
   output logic                              soft_reset_o,
   output logic [axis_in_pkg::LEVEL_W-1:0]    threshold_o,
   output logic                              cpu_pop_o
);

   import axis_in_pkg::*;

   logic                  access;
   logic                  wr_access;
   logic                  rd_access;
   logic                  addr_hit;
   logic                  data_rd;
   logic                  enable_q;
   logic [LEVEL_W-1:0]    threshold_q;
   logic [DATA_W-1:0]     status_word;
   logic [DATA_W-1:0]     rdata;

   // zero-wait slave, second cycle of every transfer is the access phase
   assign access    = psel_i & penable_i;
   assign wr_access = access & pwrite_i;
   assign rd_access = access & ~pwrite_i;
   assign pready_o  = access;

   // control registers
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         enable_q    <= 1'b0;
         threshold_q <= LEVEL_W'(2 ** FIFO_ADDR_W);
      end else if (wr_access) begin
         if (paddr_i == REG_CTRL) begin
            enable_q <= pwdata_i[CTRL_ENABLE_BIT];
         end
         if (paddr_i == REG_THRESH) begin
            threshold_q <= pwdata_i[LEVEL_W-1:0];
         end
      end
   end

   // pulse lasts exactly the access cycle, so it acts on the closing edge
   assign soft_reset_o = wr_access && (paddr_i == REG_CTRL) && pwdata_i[CTRL_SOFT_RESET_BIT];

   assign enable_o    = enable_q;
   assign threshold_o = threshold_q;

   always_comb begin
      status_word                  = '0;
      status_word[STAT_EMPTY_BIT]  = empty_i;
      status_word[STAT_FULL_BIT]   = full_i;
      status_word[STAT_TLAST_BIT]  = tlast_seen_i;
      status_word[STAT_DVALID_BIT] = hold_valid_i;
   end

   // address decode and read mux
   always_comb begin
      addr_hit = 1'b1;
      rdata    = '0;
      case (paddr_i)
         REG_CTRL: begin
            rdata[CTRL_ENABLE_BIT] = enable_q;
         end
         REG_THRESH: rdata = DATA_W'(threshold_q);
         REG_STATUS: rdata = status_word;
         REG_LEVEL:  rdata = DATA_W'(level_i);
         REG_NWORDS: rdata = nwords_i;
         REG_DATA:   rdata = hold_data_i;
         default:    addr_hit = 1'b0;
      endcase
   end

   assign prdata_o = rd_access ? rdata : '0;

   assign data_rd = rd_access && (paddr_i == REG_DATA);

   // a data read only pops when the drain stage has a word
   assign cpu_pop_o = data_rd & hold_valid_i;

   assign pslverr_o = (access & ~addr_hit) | (data_rd & ~hold_valid_i);

endmodule

/* hdl/axis_in_pkg.sv */
package axis_in_pkg;

   // data path and bus widths
   localparam int DATA_W      = 32;
   localparam int APB_ADDR_W  = 5;

   // fifo holds 2**FIFO_ADDR_W words
   localparam int FIFO_ADDR_W = 4;
   // one extra bit so the level can reach the full depth
   localparam int LEVEL_W     = FIFO_ADDR_W + 1;

   // register map, byte offsets
   localparam logic [APB_ADDR_W-1:0] REG_CTRL   = 5'h00;
   localparam logic [APB_ADDR_W-1:0] REG_THRESH = 5'h04;
   localparam logic [APB_ADDR_W-1:0] REG_STATUS = 5'h08;
   localparam logic [APB_ADDR_W-1:0] REG_LEVEL  = 5'h0C;
   localparam logic [APB_ADDR_W-1:0] REG_NWORDS = 5'h10;
   localparam logic [APB_ADDR_W-1:0] REG_DATA   = 5'h14;

   // control register fields
   localparam int CTRL_ENABLE_BIT     = 0;
   // write-only, reads back as zero
   localparam int CTRL_SOFT_RESET_BIT = 1;

   // status register fields
   localparam int STAT_EMPTY_BIT  = 0;
   localparam int STAT_FULL_BIT   = 1;
   localparam int STAT_TLAST_BIT  = 2;
   localparam int STAT_DVALID_BIT = 3;

endpackage
